// ==== build.f ====
hdl/msx_bus_pkg.sv
hdl/vdp_pkg.sv
hdl/vdp_access_fsm.sv
hdl/vdp_raster_timer.sv
hdl/vdp_regs.sv
hdl/vdp_video_out.sv
hdl/vdp_vram.sv
hdl/dev_tms.sv
hdl/msx_vdp_top.sv
sim/vdp_props.sv
sim/tb_msx_vdp.sv

// ==== hdl/dev_tms.sv ====
// --------------------------------------------------
// TMS-style VDP device
// Port decode, output gating on enable, and the
// access FSM, raster timer, registers and video
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dev_tms (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire msx_bus_pkg::cpu_req_t   cpu_i,
    input  wire msx_bus_pkg::io_device_t io_device_i,
    input  wire logic                   border_i,
    input  wire logic             [7:0] vram_rdata_i,
    output vdp_pkg::vram_req_t          vram_o,
    output logic                        vram_en_o,
    output logic                  [7:0] data_o,
    output logic                        ack_o,
    output logic                        int_o,
    output msx_bus_pkg::video_out_t     video_o
);

    import msx_bus_pkg::*;
    import vdp_pkg::*;

    logic       sel;
    logic       slot;
    logic       frame_tick;
    logic       hs;
    logic       vs;
    logic       de;
    logic       hblank;
    logic       vblank;
    logic [3:0] backdrop;
    logic [7:0] status;
    logic       status_rd;
    logic [7:0] rdata;
    logic       int_raw;
    reg_wr_t    reg_wr;
    video_out_t video_raw;

    // I/O cycle outside opcode fetch whose masked address hits our port
    assign sel = io_device_i.enable && cpu_i.iorq && !cpu_i.m1 &&
                 ((cpu_i.addr & io_device_i.mask) == io_device_i.port);

    // Bus floats high unless we are driving a read value
    assign data_o  = (sel && ack_o) ? rdata : 8'hFF;
    assign int_o   = io_device_i.enable && int_raw;
    assign video_o = io_device_i.enable ? video_raw : '0;

    vdp_access_fsm u_access (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .req_i(cpu_i.req && sel), .rd_i(cpu_i.rd), .wr_i(cpu_i.wr),
        .mode_i(cpu_i.addr[0]), .wdata_i(cpu_i.data), .slot_i(slot),
        .vram_rdata_i(vram_rdata_i), .status_i(status), .vram_o(vram_o),
        .vram_en_o(vram_en_o), .reg_o(reg_wr), .status_rd_o(status_rd),
        .rdata_o(rdata), .ack_o(ack_o)
    );

    // Param bit 0 selects the PAL line count
    vdp_raster_timer u_timer (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .pal_i(io_device_i.param[0]),
        .h_o(), .v_o(), .hs_o(hs), .vs_o(vs), .de_o(de),
        .hblank_o(hblank), .vblank_o(vblank),
        .frame_tick_o(frame_tick), .slot_o(slot)
    );

    vdp_regs u_regs (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .reg_i(reg_wr),
        .status_rd_i(status_rd), .frame_tick_i(frame_tick),
        .backdrop_o(backdrop), .status_o(status), .int_o(int_raw)
    );

    vdp_video_out u_video (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .backdrop_i(backdrop),
        .hs_i(hs), .vs_i(vs), .de_i(de), .hblank_i(hblank),
        .vblank_i(vblank), .border_i(border_i), .video_o(video_raw)
    );

endmodule

`default_nettype wire

// ==== hdl/msx_bus_pkg.sv ====
// --------------------------------------------------
// Bus-side types shared across the computer
// CPU I/O request, I/O device descriptor and
// the video output bundle
// --------------------------------------------------
`default_nettype none

package msx_bus_pkg;

    // One CPU I/O cycle as seen by a device
    // The fields stay stable while req is high
    typedef struct packed {
        logic       req;
        logic       rd;
        logic       wr;
        logic       iorq;
        logic       m1;
        logic [7:0] addr;
        logic [7:0] data;
    } cpu_req_t;

    // Port decode and option bits for one device slot
    // A device answers when addr AND mask equals port
    typedef struct packed {
        logic       enable;
        logic [7:0] port;
        logic [7:0] mask;
        logic [7:0] param;
    } io_device_t;

    // Pixel colour and raster timing toward the scaler
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       hs;
        logic       vs;
        logic       de;
        logic       hblank;
        logic       vblank;
    } video_out_t;

endpackage

`default_nettype wire

// ==== hdl/msx_vdp_top.sv ====
// --------------------------------------------------
// VDP top level
// VDP device joined with its internal VRAM
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module msx_vdp_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire msx_bus_pkg::cpu_req_t   cpu_i,
    input  wire msx_bus_pkg::io_device_t io_device_i,
    input  wire logic                   border_i,
    output logic                  [7:0] data_o,
    output logic                        ack_o,
    output logic                        int_o,
    output msx_bus_pkg::video_out_t     video_o
);

    import vdp_pkg::*;

    vram_req_t  vram_req;
    logic       vram_en;
    logic [7:0] vram_rdata;

    dev_tms u_tms (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .cpu_i(cpu_i),
        .io_device_i(io_device_i), .border_i(border_i),
        .vram_rdata_i(vram_rdata), .vram_o(vram_req), .vram_en_o(vram_en),
        .data_o(data_o), .ack_o(ack_o), .int_o(int_o), .video_o(video_o)
    );

    // VRAM sits inside the top, there is no external memory bus
    vdp_vram u_vram (
        .clk_i(clk_i), .en_i(vram_en), .req_i(vram_req), .rdata_o(vram_rdata)
    );

endmodule

`default_nettype wire

// ==== hdl/vdp_access_fsm.sv ====
// --------------------------------------------------
// VDP port access state machine
// Four-phase CPU handshake with VRAM slot wait,
// VRAM address pointer, control byte toggle,
// first-byte latch and read-ahead latch
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vdp_access_fsm (
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         req_i,
    input  wire logic         rd_i,
    input  wire logic         wr_i,
    input  wire logic         mode_i,
    input  wire logic   [7:0] wdata_i,
    input  wire logic         slot_i,
    input  wire logic   [7:0] vram_rdata_i,
    input  wire logic   [7:0] status_i,
    output vdp_pkg::vram_req_t vram_o,
    output logic              vram_en_o,
    output vdp_pkg::reg_wr_t  reg_o,
    output logic              status_rd_o,
    output logic        [7:0] rdata_o,
    output logic              ack_o
);

    import vdp_pkg::*;

    access_state_e state_q;
    access_state_e state_d;
    logic   [13:0] ptr_q;
    logic          toggle_q;
    logic    [7:0] first_q;
    logic    [7:0] latch_q;
    logic          fill_q;
    logic   [13:0] new_ptr;
    logic          ctrl_wr2;
    logic          prefetch;
    logic          need_vram;
    logic          fire;

    // Second control byte completes either a register write or an address set
    assign ctrl_wr2  = mode_i && wr_i && toggle_q;
    // Address set for reading also fetches the first byte
    assign prefetch  = ctrl_wr2 && !wdata_i[7] && !wdata_i[6];
    assign new_ptr   = {wdata_i[5:0], first_q};
    // Data port always touches VRAM, control port only on prefetch
    assign need_vram = !mode_i || prefetch;
    // The access takes effect once, in the first cycle a slot is free
    assign fire      = (state_q == EXEC || state_q == WAIT_SLOT) && (!need_vram || slot_i);

    // Ack covers the wait for req to fall plus one cycle after it
    assign ack_o = (state_q == ACK) || (state_q == RELEASE);

    // Strobes toward VRAM and the register file, valid only in the fire cycle
    always_comb begin
        vram_en_o    = fire && need_vram;
        vram_o.we    = fire && !mode_i && wr_i;
        vram_o.addr  = prefetch ? new_ptr : ptr_q;
        vram_o.wdata = wdata_i;
        reg_o.we     = fire && ctrl_wr2 && wdata_i[7];
        reg_o.idx    = wdata_i[2:0];
        reg_o.value  = first_q;
        status_rd_o  = fire && mode_i && rd_i;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = EXEC;
                end
            end
            EXEC, WAIT_SLOT: begin
                state_d = fire ? ACK : WAIT_SLOT;
            end
            // Hold ack for as long as the CPU holds req
            ACK: begin
                if (!req_i) begin
                    state_d = RELEASE;
                end
            end
            RELEASE: begin
                if (!req_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            ptr_q    <= '0;
            toggle_q <= 1'b0;
            first_q  <= '0;
            latch_q  <= '0;
            fill_q   <= 1'b0;
            rdata_o  <= 8'hFF;
        end else begin
            state_q <= state_d;
            // VRAM read data arrives one cycle after the request
            fill_q  <= vram_en_o && !vram_o.we;
            if (fill_q) begin
                latch_q <= vram_rdata_i;
            end
            if (fire) begin
                rdata_o <= 8'hFF;
                if (!mode_i) begin
                    // Data port returns the old latch, the refill follows
                    toggle_q <= 1'b0;
                    ptr_q    <= ptr_q + 14'd1;
                    if (rd_i) begin
                        rdata_o <= latch_q;
                    end
                end else if (rd_i) begin
                    rdata_o  <= status_i;
                    toggle_q <= 1'b0;
                end else if (wr_i) begin
                    if (!toggle_q) begin
                        first_q  <= wdata_i;
                        toggle_q <= 1'b1;
                    end else begin
                        toggle_q <= 1'b0;
                        if (!wdata_i[7]) begin
                            ptr_q <= prefetch ? new_ptr + 14'd1 : new_ptr;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vdp_pkg.sv ====
// --------------------------------------------------
// VDP internal types and constants
// Access FSM states, VRAM and register requests,
// shrunk raster geometry and the colour palette
// --------------------------------------------------
`default_nettype none

package vdp_pkg;

    // Port access sequence of the CPU side
    typedef enum logic [2:0] {
        IDLE,
        EXEC,
        WAIT_SLOT,
        ACK,
        RELEASE
    } access_state_e;

    // One VRAM cycle, read when we is low
    typedef struct packed {
        logic        we;
        logic [13:0] addr;
        logic  [7:0] wdata;
    } vram_req_t;

    // One control register write
    typedef struct packed {
        logic       we;
        logic [2:0] idx;
        logic [7:0] value;
    } reg_wr_t;

    // Raster geometry shrunk for simulation, one clock per pixel
    localparam int CNT_W        = 5;
    localparam int H_TOTAL      = 32;
    localparam int H_ACTIVE     = 24;
    localparam int H_SYNC_START = 26;
    localparam int H_SYNC_LEN   = 3;
    localparam int V_ACTIVE     = 16;
    localparam int V_TOTAL_NTSC = 20;
    localparam int V_TOTAL_PAL  = 24;
    localparam int V_SYNC_LINE  = 18;

    localparam int VRAM_DEPTH   = 16384;

    // Fixed TMS9918 colours as 8-bit RGB, entry 0 is transparent
    localparam logic [23:0] PALETTE [16] = '{
        24'h000000, 24'h000000, 24'h21C842, 24'h5EDC78,
        24'h5455ED, 24'h7D76FC, 24'hD4524D, 24'h42EBF5,
        24'hFC5554, 24'hFF7978, 24'hD4C154, 24'hE6CE80,
        24'h21B03B, 24'hC95BBA, 24'hCCCCCC, 24'hFFFFFF
    };

endpackage

`default_nettype wire

// ==== hdl/vdp_raster_timer.sv ====
// --------------------------------------------------
// Raster timer
// Horizontal and line counters with sync, blank,
// display enable, frame tick and CPU VRAM slots
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vdp_raster_timer (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       pal_i,
    output logic      [4:0] h_o,
    output logic      [4:0] v_o,
    output logic            hs_o,
    output logic            vs_o,
    output logic            de_o,
    output logic            hblank_o,
    output logic            vblank_o,
    output logic            frame_tick_o,
    output logic            slot_o
);

    import vdp_pkg::*;

    logic [CNT_W-1:0] h_q;
    logic [CNT_W-1:0] v_q;
    logic [CNT_W-1:0] v_last;

    // PAL frames carry four more lines than NTSC
    assign v_last = pal_i ? CNT_W'(V_TOTAL_PAL - 1) : CNT_W'(V_TOTAL_NTSC - 1);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            h_q <= '0;
            v_q <= '0;
        end else if (h_q == CNT_W'(H_TOTAL - 1)) begin
            h_q <= '0;
            // Also wraps if the standard changes on a line past the new end
            v_q <= (v_q >= v_last) ? '0 : v_q + 1'b1;
        end else begin
            h_q <= h_q + 1'b1;
        end
    end

    assign h_o          = h_q;
    assign v_o          = v_q;
    assign hblank_o     = h_q >= CNT_W'(H_ACTIVE);
    assign vblank_o     = v_q >= CNT_W'(V_ACTIVE);
    assign de_o         = !hblank_o && !vblank_o;
    assign hs_o         = (h_q >= CNT_W'(H_SYNC_START)) &&
                          (h_q < CNT_W'(H_SYNC_START + H_SYNC_LEN));
    assign vs_o         = v_q == CNT_W'(V_SYNC_LINE);
    // First cycle of the first blank line
    assign frame_tick_o = (h_q == '0) && (v_q == CNT_W'(V_ACTIVE));
    // One CPU slot in every four pixels
    assign slot_o       = h_q[1:0] == 2'b11;

endmodule

`default_nettype wire

// ==== hdl/vdp_regs.sv ====
// --------------------------------------------------
// VDP control registers
// Eight write-only registers, status frame flag
// and the frame interrupt
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vdp_regs (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire vdp_pkg::reg_wr_t reg_i,
    input  wire logic       status_rd_i,
    input  wire logic       frame_tick_i,
    output logic      [3:0] backdrop_o,
    output logic      [7:0] status_o,
    output logic            int_o
);

    logic [7:0] regs_q [8];
    logic       frame_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 8; i++) begin
                regs_q[i] <= '0;
            end
            frame_q <= 1'b0;
        end else begin
            if (reg_i.we) begin
                regs_q[reg_i.idx] <= reg_i.value;
            end
            // A new frame wins over a status read in the same cycle
            if (frame_tick_i) begin
                frame_q <= 1'b1;
            end else if (status_rd_i) begin
                frame_q <= 1'b0;
            end
        end
    end

    // Sprite bits are not modelled and read as zero
    assign status_o   = {frame_q, 7'b0};
    // Register 1 bit 5 is the interrupt enable
    assign int_o      = frame_q && regs_q[1][5];
    // Low nibble of register 7 selects the backdrop colour
    assign backdrop_o = regs_q[7][3:0];

endmodule

`default_nettype wire

// ==== hdl/vdp_video_out.sv ====
// --------------------------------------------------
// Video output stage
// Palette lookup of the backdrop, blank gating
// and one register stage for colour and timing
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vdp_video_out (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic [3:0] backdrop_i,
    input  wire logic       hs_i,
    input  wire logic       vs_i,
    input  wire logic       de_i,
    input  wire logic       hblank_i,
    input  wire logic       vblank_i,
    input  wire logic       border_i,
    output msx_bus_pkg::video_out_t video_o
);

    import vdp_pkg::*;

    logic [23:0] rgb;

    // Black outside the active area, entry 0 when the border is forced
    always_comb begin
        if (!de_i) begin
            rgb = '0;
        end else if (border_i) begin
            rgb = PALETTE[0];
        end else begin
            rgb = PALETTE[backdrop_i];
        end
    end

    // Everything lands one cycle after the raster counters
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            video_o <= '0;
        end else begin
            video_o.r      <= rgb[23:16];
            video_o.g      <= rgb[15:8];
            video_o.b      <= rgb[7:0];
            video_o.hs     <= hs_i;
            video_o.vs     <= vs_i;
            video_o.de     <= de_i;
            video_o.hblank <= hblank_i;
            video_o.vblank <= vblank_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vdp_vram.sv ====
// --------------------------------------------------
// Video RAM
// 16 KiB single-port synchronous memory,
// read returns the contents before the write
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vdp_vram (
    input  wire logic       clk_i,
    input  wire logic       en_i,
    input  wire vdp_pkg::vram_req_t req_i,
    output logic      [7:0] rdata_o
);

    import vdp_pkg::*;

    logic [7:0] mem [VRAM_DEPTH];

    // Read-first port, a write returns the old byte
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (req_i.we) begin
                mem[req_i.addr] <= req_i.wdata;
            end
            rdata_o <= mem[req_i.addr];
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the VDP testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_msx_vdp -f build.f -Mdir obj_dir

# The verdict comes from the printed result line
sim_out="$(./obj_dir/Vtb_msx_vdp 2>&1)" || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi

// ==== sim/tb_msx_vdp.sv ====
// --------------------------------------------------
// Testbench for the VDP top level
// Clock and reset, four-phase port tasks, a step
// table for VRAM and registers, typed compare
// tasks, raster checks and a cycle timeout
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_msx_vdp;

    import msx_bus_pkg::*;
    import vdp_pkg::*;

    localparam logic [7:0] DATA_PORT = 8'h98;
    localparam logic [7:0] CTRL_PORT = 8'h99;
    localparam int NUM_STEPS   = 22;
    // Handshakes outside the table, plus frame waits in the raster tests
    localparam int EXTRA_OPS   = 16;
    localparam int FRAME_WAITS = 10;
    localparam int MAX_CYCLES  = 16 + (NUM_STEPS + EXTRA_OPS) * 16 +
                                 FRAME_WAITS * H_TOTAL * V_TOTAL_PAL;
    localparam int FRAME_SPAN  = H_TOTAL * V_TOTAL_NTSC + H_TOTAL;

    typedef enum logic {OP_WR, OP_RD} op_e;

    // One port access and the byte seen on data_o while ack is high
    typedef struct packed {
        op_e        op;
        logic [7:0] port;
        logic [7:0] data;
        logic [7:0] exp_rd;
    } step_t;

    logic       clk = 1'b0;
    logic       rst_n;
    cpu_req_t   cpu;
    io_device_t io_dev;
    logic       border;
    logic [7:0] data;
    logic       ack;
    logic       irq;
    video_out_t video;
    step_t      steps [NUM_STEPS];
    int         cycles = 0;

    always #10 clk = ~clk;

    msx_vdp_top u_dut (
        .clk_i(clk), .rst_n_i(rst_n), .cpu_i(cpu), .io_device_i(io_dev),
        .border_i(border), .data_o(data), .ack_o(ack), .int_o(irq), .video_o(video)
    );

    // Run limit counted in clocks from time zero
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "Stopped by timeout");
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_video(input string name, input video_out_t got, input video_out_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_period(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Full four-phase cycle, the read value is taken while ack is high
    task automatic port_access(input op_e op, input logic [7:0] port,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        cpu.req  <= 1'b1;
        cpu.rd   <= (op == OP_RD);
        cpu.wr   <= (op == OP_WR);
        cpu.iorq <= 1'b1;
        cpu.addr <= port;
        cpu.data <= wdata;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 8) begin
                stop_on_error("No ack within 8 cycles of a port request");
            end
        end while (!ack);
        rdata = data;
        @(posedge clk);
        cpu.req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 4) begin
                stop_on_error("Ack stayed high after the request was released");
            end
        end while (ack);
        @(posedge clk);
        cpu.rd   <= 1'b0;
        cpu.wr   <= 1'b0;
        cpu.iorq <= 1'b0;
    endtask

    task automatic wait_video_de(input logic level);
        do begin
            @(negedge clk);
        end while (video.de !== level);
    endtask

    // Aligns to one rising edge of vs and counts clocks to the next
    task automatic measure_vs_period(output int span);
        logic prev;
        do begin
            prev = video.vs;
            @(negedge clk);
        end while (!(video.vs && !prev));
        span = 0;
        do begin
            prev = video.vs;
            @(negedge clk);
            span++;
        end while (!(video.vs && !prev));
    endtask

    initial begin
        logic [7:0] rnd;
        logic [7:0] rd_val;
        video_out_t exp_vid;
        int         period;
        void'($urandom(1916));
        rst_n  = 1'b0;
        cpu    = '0;
        io_dev = '{enable: 1'b1, port: DATA_PORT, mask: 8'hFE, param: 8'h00};
        border = 1'b0;

        // Backdrop 5 into register 7, then address 0x1234 for writing
        steps[0] = '{OP_WR, CTRL_PORT, 8'h05, 8'hFF};
        steps[1] = '{OP_WR, CTRL_PORT, 8'h87, 8'hFF};
        steps[2] = '{OP_WR, CTRL_PORT, 8'h34, 8'hFF};
        steps[3] = '{OP_WR, CTRL_PORT, 8'h52, 8'hFF};
        // Same address for reading, which also fills the read-ahead latch
        steps[12] = '{OP_WR, CTRL_PORT, 8'h34, 8'hFF};
        steps[13] = '{OP_WR, CTRL_PORT, 8'h12, 8'hFF};
        for (int k = 0; k < 8; k++) begin
            rnd = 8'($urandom());
            steps[4 + k]  = '{OP_WR, DATA_PORT, rnd, 8'hFF};
            steps[14 + k] = '{OP_RD, DATA_PORT, 8'h00, rnd};
        end

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < NUM_STEPS; i++) begin
            port_access(steps[i].op, steps[i].port, steps[i].data, rd_val);
            check_byte($sformatf("data_o step %0d", i), rd_val, steps[i].exp_rd);
        end

        // Any active pixel shows the backdrop, the first pixel after it is hblank
        exp_vid = '0;
        {exp_vid.r, exp_vid.g, exp_vid.b} = PALETTE[5];
        exp_vid.de = 1'b1;
        wait_video_de(1'b1);
        check_video("video_o active", video, exp_vid);
        exp_vid = '0;
        exp_vid.hblank = 1'b1;
        wait_video_de(1'b0);
        check_video("video_o blank", video, exp_vid);

        // Border input replaces the backdrop with palette entry 0
        @(posedge clk);
        border <= 1'b1;
        exp_vid = '0;
        {exp_vid.r, exp_vid.g, exp_vid.b} = PALETTE[0];
        exp_vid.de = 1'b1;
        wait_video_de(1'b0);
        wait_video_de(1'b1);
        check_video("video_o border", video, exp_vid);
        @(posedge clk);
        border <= 1'b0;

        // Interrupt enabled in register 1, stale frame flag cleared first
        port_access(OP_WR, CTRL_PORT, 8'h20, rd_val);
        port_access(OP_WR, CTRL_PORT, 8'h81, rd_val);
        port_access(OP_RD, CTRL_PORT, 8'h00, rd_val);
        do begin
            @(negedge clk);
        end while (!irq);
        port_access(OP_RD, CTRL_PORT, 8'h00, rd_val);
        check_byte("data_o status", rd_val, 8'h80);
        check_bit("int_o after status read", irq, 1'b0);
        port_access(OP_RD, CTRL_PORT, 8'h00, rd_val);
        check_byte("data_o second status", rd_val, 8'h00);

        // Interrupt disabled, the flag still sets over a frame
        port_access(OP_WR, CTRL_PORT, 8'h00, rd_val);
        port_access(OP_WR, CTRL_PORT, 8'h81, rd_val);
        repeat (FRAME_SPAN) begin
            @(negedge clk);
            check_bit("int_o masked", irq, 1'b0);
        end
        port_access(OP_RD, CTRL_PORT, 8'h00, rd_val);
        check_byte("data_o status masked", rd_val, 8'h80);

        // Address 0x10 misses the 0x98 mask 0xFE decode
        @(posedge clk);
        cpu <= '{req: 1'b1, rd: 1'b1, wr: 1'b0, iorq: 1'b1, m1: 1'b0,
                 addr: 8'h10, data: 8'h00};
        repeat (8) begin
            @(negedge clk);
            check_bit("ack_o unselected", ack, 1'b0);
            check_byte("data_o unselected", data, 8'hFF);
        end
        @(posedge clk);
        cpu <= '0;

        // Disabled device hides video and the pending interrupt
        port_access(OP_WR, CTRL_PORT, 8'h20, rd_val);
        port_access(OP_WR, CTRL_PORT, 8'h81, rd_val);
        port_access(OP_RD, CTRL_PORT, 8'h00, rd_val);
        @(posedge clk);
        io_dev.enable <= 1'b0;
        repeat (FRAME_SPAN) begin
            @(negedge clk);
            check_video("video_o disabled", video, '0);
            check_bit("int_o disabled", irq, 1'b0);
        end
        @(posedge clk);
        io_dev.enable <= 1'b1;
        @(negedge clk);
        check_bit("int_o enabled again", irq, 1'b1);
        port_access(OP_RD, CTRL_PORT, 8'h00, rd_val);
        check_byte("data_o status enabled again", rd_val, 8'h80);

        // Frame length follows param bit 0
        @(posedge clk);
        io_dev.param <= 8'h01;
        measure_vs_period(period);
        check_period("vs period PAL", period, V_TOTAL_PAL * H_TOTAL);
        @(posedge clk);
        io_dev.param <= 8'h00;
        measure_vs_period(period);
        check_period("vs period NTSC", period, V_TOTAL_NTSC * H_TOTAL);

        if (u_dut.u_tms.u_access.u_props.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Handshake assertions failed %0d times",
                     u_dut.u_tms.u_access.u_props.fail_count);
            $display("Verification failed");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

`default_nettype wire

// ==== sim/vdp_props.sv ====
// --------------------------------------------------
// Concurrent assertions for the access FSM
// Ack against req, ack release and RELEASE hold
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module vdp_props (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   req_i,
    input  wire logic                   ack_i,
    input  wire vdp_pkg::access_state_e state_i
);

    import vdp_pkg::*;

    int fail_count = 0;

    // Ack only ever answers a pending request
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> req_i)
        else begin
            fail_count++;
            $error("ack rose while req was low");
        end

    // RELEASE takes one cycle after ACK, so two clocks at most
    ack_drops: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(req_i) |-> ##[0:2] !ack_i)
        else begin
            fail_count++;
            $error("ack still high two cycles after req fell");
        end

    // A new request must not slip in before the old one is closed
    release_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_i == RELEASE) && req_i |=> state_i == RELEASE)
        else begin
            fail_count++;
            $error("state left RELEASE while req was high");
        end

endmodule

bind vdp_access_fsm vdp_props u_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(req_i), .ack_i(ack_o), .state_i(state_q)
);

`default_nettype wire
